/* src/ddr_ui_pkg.sv */
package ddr_ui_pkg;

    // Fixed geometry
    localparam int DATA_WIDTH     = 128;
    localparam int ADDR_WIDTH     = 26;
    localparam int ADDR_PAD_BITS  = 3;
    localparam int APP_ADDR_WIDTH = ADDR_WIDTH + ADDR_PAD_BITS;   // 29 bits

    // MIG app_cmd encoding
    typedef enum logic [2:0] {
        APP_CMD_WRITE = 3'd0,
        APP_CMD_READ  = 3'd1,
        APP_CMD_NONE  = 3'd3    // Idle code
    } app_cmd_e;

    typedef enum logic [1:0] {
        CALIBRATION,
        IDLE,
        WRITE,
        READ
    } seq_state_e;

    // What the sequencer wants on the command bus
    typedef enum logic [1:0] {
        OP_NONE,
        OP_READ,
        OP_WRITE
    } seq_op_e;

    typedef struct packed {
        logic                      en;
        app_cmd_e                  cmd;
        logic [APP_ADDR_WIDTH-1:0] addr;
    } app_req_t;

    typedef struct packed {
        logic                  wren;
        logic                  last;   // Drives app_wdf_end
        logic [DATA_WIDTH-1:0] data;
    } app_wdf_t;

    // Levels coming back from the MIG
    typedef struct packed {
        logic rdy;
        logic wdf_rdy;
        logic calib_done;
    } app_status_t;

    typedef struct packed {
        logic                  valid;
        logic [DATA_WIDTH-1:0] data;
    } app_rsp_t;

endpackage

/* src/ddr_cmd_sequencer.sv */
`timescale 1ns/1ns

module ddr_cmd_sequencer (
    input  logic                    ui_clk,
    input  logic                    ui_clk_sync_rst,
    input  logic                    wr_en,
    input  logic                    rd_en,
    input  ddr_ui_pkg::app_status_t app_status,
    output logic                    wr_busy,
    output logic                    rd_busy,
    output ddr_ui_pkg::seq_op_e     cur_op,
    output logic                    wdf_fire
);
    import ddr_ui_pkg::*;

    seq_state_e state;
    seq_state_e state_next;

    // One request of the other kind can wait here
    logic wr_pend;
    logic wr_pend_next;
    logic rd_pend;
    logic rd_pend_next;

    logic rd_accept;
    logic wr_accept;

    // Acceptance of the command currently on the bus
    assign rd_accept = (state == READ) && app_status.rdy;
    assign wr_accept = (state == WRITE) && app_status.rdy && app_status.wdf_rdy;

    always_comb begin
        state_next   = state;
        wr_pend_next = wr_pend;
        rd_pend_next = rd_pend;

        case (state)
            CALIBRATION: begin
                if (app_status.calib_done) begin
                    state_next = IDLE;
                end
            end

            IDLE: begin
                wr_pend_next = 1'b0;
                rd_pend_next = 1'b0;
                if (rd_en) begin
                    state_next   = READ;
                    wr_pend_next = wr_en;   // Read first, write waits
                end else if (wr_en) begin
                    state_next = WRITE;
                end
            end

            READ: begin
                rd_pend_next = 1'b0;
                wr_pend_next = wr_pend | wr_en;
                if (rd_accept) begin
                    if (wr_pend) begin
                        // Waiting write goes next
                        state_next   = WRITE;
                        wr_pend_next = 1'b0;
                        rd_pend_next = rd_en;
                    end else if (rd_en) begin
                        state_next = READ;
                    end else if (wr_en) begin
                        state_next   = WRITE;
                        wr_pend_next = 1'b0;
                    end else begin
                        state_next = IDLE;
                    end
                end
            end

            WRITE: begin
                wr_pend_next = 1'b0;
                rd_pend_next = rd_pend | rd_en;
                if (wr_accept) begin
                    if (rd_pend || rd_en) begin
                        state_next   = READ;
                        rd_pend_next = 1'b0;
                        wr_pend_next = wr_en;
                    end else if (wr_en) begin
                        state_next = WRITE;   // Back to back writes
                    end else begin
                        state_next = IDLE;
                    end
                end
            end

            default: begin
                state_next = CALIBRATION;
            end
        endcase
    end

    // Busy levels and the op presented to the driver
    always_comb begin
        cur_op   = OP_NONE;
        wdf_fire = 1'b0;
        wr_busy  = 1'b0;
        rd_busy  = 1'b0;

        case (state)
            CALIBRATION: begin
                wr_busy = 1'b1;
                rd_busy = 1'b1;
            end

            IDLE: begin
                cur_op = OP_NONE;
            end

            READ: begin
                cur_op  = OP_READ;
                rd_busy = ~rd_accept;   // Frees rd_en in the accept cycle
                wr_busy = wr_pend;
            end

            WRITE: begin
                cur_op   = OP_WRITE;
                wdf_fire = wr_accept;   // Data goes with the command
                wr_busy  = ~wr_accept;
                rd_busy  = rd_pend;
            end

            default: begin
                wr_busy = 1'b1;
                rd_busy = 1'b1;
            end
        endcase
    end

    always_ff @(posedge ui_clk) begin
        if (ui_clk_sync_rst) begin
            state   <= CALIBRATION;
            wr_pend <= 1'b0;
            rd_pend <= 1'b0;
        end else begin
            state   <= state_next;
            wr_pend <= wr_pend_next;
            rd_pend <= rd_pend_next;
        end
    end

endmodule

/* src/ddr_app_driver.sv */
`timescale 1ns/1ns

module ddr_app_driver (
    input  logic                              ui_clk,
    input  logic                              ui_clk_sync_rst,
    input  logic                              wr_en,
    input  logic [ddr_ui_pkg::ADDR_WIDTH-1:0] wr_addr,
    input  logic [ddr_ui_pkg::DATA_WIDTH-1:0] wr_data,
    input  logic                              rd_en,
    input  logic [ddr_ui_pkg::ADDR_WIDTH-1:0] rd_addr,
    input  ddr_ui_pkg::seq_op_e               cur_op,
    input  logic                              wdf_fire,
    output ddr_ui_pkg::app_req_t              app_req,
    output ddr_ui_pkg::app_wdf_t              app_wdf
);
    import ddr_ui_pkg::*;

    // Captured user requests
    logic [ADDR_WIDTH-1:0] wr_addr_q;
    logic [DATA_WIDTH-1:0] wr_data_q;
    logic [ADDR_WIDTH-1:0] rd_addr_q;

    // User word address to MIG address, low bits zero
    function automatic logic [APP_ADDR_WIDTH-1:0] to_app_addr(
        input logic [ADDR_WIDTH-1:0] word_addr
    );
        return {word_addr, {ADDR_PAD_BITS{1'b0}}};
    endfunction

    // Every strobe reloads, even while busy
    always_ff @(posedge ui_clk) begin
        if (ui_clk_sync_rst) begin
            wr_addr_q <= '0;
            wr_data_q <= '0;
            rd_addr_q <= '0;
        end else begin
            if (wr_en) begin
                wr_addr_q <= wr_addr;
                wr_data_q <= wr_data;
            end
            if (rd_en) begin
                rd_addr_q <= rd_addr;
            end
        end
    end

    always_comb begin
        app_req.en   = 1'b0;
        app_req.cmd  = APP_CMD_NONE;
        app_req.addr = '0;

        case (cur_op)
            OP_READ: begin
                app_req.en   = 1'b1;
                app_req.cmd  = APP_CMD_READ;
                app_req.addr = to_app_addr(rd_addr_q);
            end

            OP_WRITE: begin
                app_req.en   = 1'b1;
                app_req.cmd  = APP_CMD_WRITE;
                app_req.addr = to_app_addr(wr_addr_q);
            end

            default: begin
                app_req.en = 1'b0;   // Idle, nothing on the bus
            end
        endcase
    end

    // Single beat per write, so end marks the same beat as wren
    always_comb begin
        app_wdf.wren = wdf_fire;
        app_wdf.last = wdf_fire;
        if (cur_op == OP_WRITE) begin
            app_wdf.data = wr_data_q;
        end else begin
            app_wdf.data = '0;
        end
    end

endmodule

/* src/ddr_ui_ctrl.sv */
`timescale 1ns/1ns

module ddr_ui_ctrl (
    input  logic                              ui_clk,
    input  logic                              ui_clk_sync_rst,

    // User side
    input  logic                              wr_en,
    input  logic [ddr_ui_pkg::ADDR_WIDTH-1:0] wr_addr,
    input  logic [ddr_ui_pkg::DATA_WIDTH-1:0] wr_data,
    input  logic                              rd_en,
    input  logic [ddr_ui_pkg::ADDR_WIDTH-1:0] rd_addr,
    output logic                              wr_busy,
    output logic                              rd_busy,
    output logic [ddr_ui_pkg::DATA_WIDTH-1:0] rd_data,
    output logic                              rd_data_valid,

    // MIG application interface
    output ddr_ui_pkg::app_req_t              app_req,
    output ddr_ui_pkg::app_wdf_t              app_wdf,
    input  ddr_ui_pkg::app_status_t           app_status,
    input  ddr_ui_pkg::app_rsp_t              app_rsp
);
    import ddr_ui_pkg::*;

    seq_op_e cur_op;
    logic    wdf_fire;

    ddr_cmd_sequencer u_seq (
        .ui_clk          (ui_clk),
        .ui_clk_sync_rst (ui_clk_sync_rst),
        .wr_en           (wr_en),
        .rd_en           (rd_en),
        .app_status      (app_status),
        .wr_busy         (wr_busy),
        .rd_busy         (rd_busy),
        .cur_op          (cur_op),
        .wdf_fire        (wdf_fire)
    );

    ddr_app_driver u_drv (
        .ui_clk          (ui_clk),
        .ui_clk_sync_rst (ui_clk_sync_rst),
        .wr_en           (wr_en),
        .wr_addr         (wr_addr),
        .wr_data         (wr_data),
        .rd_en           (rd_en),
        .rd_addr         (rd_addr),
        .cur_op          (cur_op),
        .wdf_fire        (wdf_fire),
        .app_req         (app_req),
        .app_wdf         (app_wdf)
    );

    // Read return goes straight through, MIG keeps issue order
    assign rd_data       = app_rsp.data;
    assign rd_data_valid = app_rsp.valid;

endmodule

/* dv/app_mem_model.sv */
`timescale 1ns/1ns

module app_mem_model (
    input  logic                    ui_clk,
    input  logic                    ui_clk_sync_rst,
    input  ddr_ui_pkg::app_req_t    app_req,
    input  ddr_ui_pkg::app_wdf_t    app_wdf,
    input  logic                    rand_stall,     // Random rdy/wdf_rdy drops
    input  logic                    hold_rdy,
    input  logic                    hold_wdf_rdy,
    output ddr_ui_pkg::app_status_t app_status,
    output ddr_ui_pkg::app_rsp_t    app_rsp
);
    import ddr_ui_pkg::*;

    logic [DATA_WIDTH-1:0] mem [256];
    logic [4:0]            calib_cnt;
    logic [3:0]            rsp_valid;   // Read return pipeline
    logic [DATA_WIDTH-1:0] rsp_data [4];
    logic [7:0]            idx;
    logic                  calibrated;

    // Power-up contents, different for every word
    function automatic logic [DATA_WIDTH-1:0] fill_word(input logic [7:0] a);
        return {4{24'h5eed00, a}};
    endfunction

    assign idx        = app_req.addr[ADDR_PAD_BITS +: 8];
    assign calibrated = (calib_cnt == 5'd20);

    always_ff @(posedge ui_clk) begin
        if (ui_clk_sync_rst) begin
            calib_cnt  <= '0;
            app_status <= '0;
            rsp_valid  <= '0;
            for (int i = 0; i < 256; i++) begin
                mem[i] <= fill_word(8'(i));
            end
        end else begin
            if (!calibrated) begin
                calib_cnt <= calib_cnt + 5'd1;
            end
            app_status.calib_done <= calibrated;
            app_status.rdy        <= calibrated && !hold_rdy &&
                                     !(rand_stall && $urandom_range(3, 0) == 0);
            app_status.wdf_rdy    <= calibrated && !hold_wdf_rdy &&
                                     !(rand_stall && $urandom_range(3, 0) == 0);

            if (app_req.en && app_status.rdy && app_req.cmd == APP_CMD_WRITE &&
                app_wdf.wren && app_status.wdf_rdy) begin
                mem[idx] <= app_wdf.data;
            end

            // Read data comes back four cycles after acceptance
            rsp_valid   <= {rsp_valid[2:0],
                            app_req.en && app_status.rdy && app_req.cmd == APP_CMD_READ};
            rsp_data[0] <= mem[idx];
            for (int i = 1; i < 4; i++) begin
                rsp_data[i] <= rsp_data[i-1];
            end
        end
    end

    assign app_rsp.valid = rsp_valid[3];
    assign app_rsp.data  = rsp_data[3];

endmodule

/* dv/ddr_ui_ctrl_properties.sv */
`timescale 1ns/1ns

module ddr_ui_ctrl_properties (
    input logic                    ui_clk,
    input logic                    ui_clk_sync_rst,
    input ddr_ui_pkg::app_req_t    app_req,
    input ddr_ui_pkg::app_wdf_t    app_wdf,
    input ddr_ui_pkg::app_status_t app_status
);
    import ddr_ui_pkg::*;

    int assert_fails = 0;

    // Stalled command holds still
    cmd_stable_while_stalled: assert property (
        @(posedge ui_clk) disable iff (ui_clk_sync_rst)
        (app_req.en && !app_status.rdy) |=>
            (app_req.en && $stable(app_req.cmd) && $stable(app_req.addr))
    ) else begin
        assert_fails++;
        $error("Command moved while rdy was low");
    end

    wren_only_with_write: assert property (
        @(posedge ui_clk) disable iff (ui_clk_sync_rst)
        app_wdf.wren |-> (app_req.en && app_req.cmd == APP_CMD_WRITE)
    ) else begin
        assert_fails++;
        $error("wren high without a write command");
    end

    addr_pad_zero: assert property (
        @(posedge ui_clk) disable iff (ui_clk_sync_rst)
        app_req.addr[ADDR_PAD_BITS-1:0] == '0
    ) else begin
        assert_fails++;
        $error("Low address bits not zero");
    end

endmodule

/* dv/tb_ddr_ui_ctrl.sv */
`timescale 1ns/1ns

module tb_ddr_ui_ctrl;
    import ddr_ui_pkg::*;

    logic ui_clk, ui_clk_sync_rst;
    logic wr_en, rd_en, wr_busy, rd_busy, rd_data_valid;
    logic [ADDR_WIDTH-1:0] wr_addr, rd_addr;
    logic [DATA_WIDTH-1:0] wr_data, rd_data;
    app_req_t    app_req;
    app_wdf_t    app_wdf;
    app_status_t app_status;
    app_rsp_t    app_rsp;
    logic rand_stall, hold_rdy, hold_wdf_rdy;

    int errors;
    int max_wait = 200;
    logic [DATA_WIDTH-1:0] exp_mem [256];
    logic [ADDR_WIDTH-1:0] wr_q_addr[$];   // Sent but not yet accepted
    logic [DATA_WIDTH-1:0] wr_q_data[$];
    logic [ADDR_WIDTH-1:0] rd_q_addr[$];
    logic [DATA_WIDTH-1:0] rsp_q[$];       // Data each accepted read must return
    app_cmd_e cmd_log[$];
    logic [APP_ADDR_WIDTH-1:0] addr_log[$];

    ddr_ui_ctrl DUT (.*);

    app_mem_model u_mem (.*);

    bind ddr_ui_ctrl ddr_ui_ctrl_properties u_props (
        .ui_clk          (ui_clk),
        .ui_clk_sync_rst (ui_clk_sync_rst),
        .app_req         (app_req),
        .app_wdf         (app_wdf),
        .app_status      (app_status)
    );

    always #4 ui_clk = ~ui_clk;

    function automatic logic [DATA_WIDTH-1:0] initial_word(input logic [7:0] a);
        return {4{24'h5eed00, a}};
    endfunction

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("Fail %0t %s expected %b got %b", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [DATA_WIDTH-1:0] exp,
                              input logic [DATA_WIDTH-1:0] got);
        if (got !== exp) begin
            $display("Fail %0t %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge ui_clk);
        #1;
    endtask

    task automatic wait_not_busy(input logic want_rd, input logic want_wr);
        int n;
        n = 0;
        while (((want_rd && rd_busy) || (want_wr && wr_busy)) && n < max_wait) begin
            next_cycle();
            n++;
        end
        if ((want_rd && rd_busy) || (want_wr && wr_busy)) begin
            $display("Timed out at %0t waiting for busy to drop", $time);
            errors++;
        end
    endtask

    task automatic send_request(input logic do_rd, input logic do_wr,
                                input logic [ADDR_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] d);
        wait_not_busy(do_rd, do_wr);
        rd_en   = do_rd;
        wr_en   = do_wr;
        rd_addr = a;
        wr_addr = a;
        wr_data = d;
        if (do_rd) begin
            rd_q_addr.push_back(a);
        end
        if (do_wr) begin
            wr_q_addr.push_back(a);
            wr_q_data.push_back(d);
        end
        next_cycle();
        rd_en = 1'b0;
        wr_en = 1'b0;
    endtask

    task automatic wait_read_data(output logic [DATA_WIDTH-1:0] data);
        int n;
        n = 0;
        @(negedge ui_clk);
        while (!rd_data_valid && n < max_wait) begin
            @(negedge ui_clk);
            n++;
        end
        if (!rd_data_valid) begin
            $display("Timed out at %0t waiting for read data", $time);
            errors++;
        end
        data = rd_data;
        next_cycle();
    endtask

    task automatic drain_queues();
        int n;
        n = 0;
        while (wr_q_addr.size() + rd_q_addr.size() + rsp_q.size() != 0 && n < max_wait) begin
            next_cycle();
            n++;
        end
        if (wr_q_addr.size() + rd_q_addr.size() + rsp_q.size() != 0) begin
            $display("Timed out at %0t with requests still outstanding", $time);
            errors++;
        end
    endtask

    // Bus monitor, sampled mid-cycle
    always @(negedge ui_clk) begin : bus_monitor
        logic write_taken;
        logic read_taken;
        write_taken = app_req.en && app_req.cmd == APP_CMD_WRITE &&
                      app_status.rdy && app_status.wdf_rdy;
        read_taken  = app_req.en && app_req.cmd == APP_CMD_READ && app_status.rdy;
        if (!ui_clk_sync_rst) begin
            check_bit("app_wdf.wren", write_taken, app_wdf.wren);
            check_bit("app_wdf.last", write_taken, app_wdf.last);
            if (write_taken || read_taken) begin
                cmd_log.push_back(app_req.cmd);
                addr_log.push_back(app_req.addr);
            end
            if (write_taken && wr_q_addr.size() == 0) begin
                $display("Write accepted at %0t with no write outstanding", $time);
                errors++;
            end else if (write_taken) begin
                check_word("app_req.addr",
                           DATA_WIDTH'({wr_q_addr[0], {ADDR_PAD_BITS{1'b0}}}),
                           DATA_WIDTH'(app_req.addr));
                check_word("app_wdf.data", wr_q_data[0], app_wdf.data);
                exp_mem[wr_q_addr[0][7:0]] = wr_q_data.pop_front();
                void'(wr_q_addr.pop_front());
            end
            if (read_taken && rd_q_addr.size() == 0) begin
                $display("Read accepted at %0t with no read outstanding", $time);
                errors++;
            end else if (read_taken) begin
                check_word("app_req.addr",
                           DATA_WIDTH'({rd_q_addr[0], {ADDR_PAD_BITS{1'b0}}}),
                           DATA_WIDTH'(app_req.addr));
                rsp_q.push_back(exp_mem[rd_q_addr[0][7:0]]);
                void'(rd_q_addr.pop_front());
            end
            if (rd_data_valid && rsp_q.size() == 0) begin
                $display("Read data returned at %0t with no read outstanding", $time);
                errors++;
            end else if (rd_data_valid) begin
                check_word("rd_data", rsp_q.pop_front(), rd_data);
            end
        end
    end

    task automatic calibration_wait();
        int n;
        n = 0;
        check_bit("app_req.en", 1'b0, app_req.en);
        check_bit("app_wdf.wren", 1'b0, app_wdf.wren);
        check_bit("app_wdf.last", 1'b0, app_wdf.last);
        if (app_req.cmd !== APP_CMD_NONE) begin
            $display("Fail %0t app_req.cmd expected %0d got %0d", $time, APP_CMD_NONE, app_req.cmd);
            errors++;
        end
        while (!app_status.calib_done && n < max_wait) begin
            check_bit("wr_busy", 1'b1, wr_busy);
            check_bit("rd_busy", 1'b1, rd_busy);
            check_bit("app_req.en", 1'b0, app_req.en);
            next_cycle();
            n++;
        end
        if (!app_status.calib_done) begin
            $display("Timed out waiting for calibration");
            errors++;
        end
        check_bit("wr_busy", 1'b1, wr_busy);   // Still calibrating this cycle
        check_bit("rd_busy", 1'b1, rd_busy);
        wait_not_busy(1'b1, 1'b1);
    endtask

    task automatic write_then_read();
        logic [ADDR_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] d;
        logic [DATA_WIDTH-1:0] got;
        a = ADDR_WIDTH'($urandom_range(255, 0));
        d = {$urandom, $urandom, $urandom, $urandom};
        addr_log.delete();
        send_request(1'b0, 1'b1, a, d);
        send_request(1'b1, 1'b0, a, '0);
        wait_read_data(got);
        check_word("rd_data", d, got);
        drain_queues();
        if (addr_log.size() != 2) begin
            $display("Expected two accepted commands, saw %0d", addr_log.size());
            errors++;
        end else begin
            check_word("app_req.addr", DATA_WIDTH'({a, 3'b000}), DATA_WIDTH'(addr_log[1]));
        end
    endtask

    task automatic same_cycle_conflict();
        logic [ADDR_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] old;
        logic [DATA_WIDTH-1:0] got;
        a   = ADDR_WIDTH'($urandom_range(255, 0));
        old = exp_mem[a[7:0]];
        cmd_log.delete();
        send_request(1'b1, 1'b1, a, {$urandom, $urandom, $urandom, $urandom});
        wait_read_data(got);
        check_word("rd_data", old, got);   // Read goes ahead of the write
        drain_queues();
        if (cmd_log.size() != 2 || cmd_log[0] != APP_CMD_READ || cmd_log[1] != APP_CMD_WRITE) begin
            $display("Conflicting requests were not issued as a read then a write");
            errors++;
        end
    endtask

    task automatic back_pressure();
        logic [ADDR_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] d;
        logic [DATA_WIDTH-1:0] got;
        a = ADDR_WIDTH'($urandom_range(255, 0));
        d = {$urandom, $urandom, $urandom, $urandom};
        hold_rdy     = 1'b1;
        hold_wdf_rdy = 1'b1;
        next_cycle();
        send_request(1'b0, 1'b1, a, d);
        repeat (10) begin
            check_bit("wr_busy", 1'b1, wr_busy);
            check_bit("app_req.en", 1'b1, app_req.en);
            check_bit("app_wdf.wren", 1'b0, app_wdf.wren);
            next_cycle();
        end
        hold_rdy = 1'b0;   // rdy back, data side still stalled
        repeat (3) begin
            next_cycle();
            check_bit("wr_busy", 1'b1, wr_busy);
            check_bit("app_wdf.wren", 1'b0, app_wdf.wren);
        end
        hold_wdf_rdy = 1'b0;
        wait_not_busy(1'b0, 1'b1);
        check_bit("app_wdf.wren", 1'b1, app_wdf.wren);
        check_bit("app_status.wdf_rdy", 1'b1, app_status.wdf_rdy);
        next_cycle();
        check_bit("app_wdf.wren", 1'b0, app_wdf.wren);

        hold_rdy = 1'b1;
        next_cycle();
        send_request(1'b1, 1'b0, a, '0);
        repeat (10) begin
            check_bit("rd_busy", 1'b1, rd_busy);
            check_bit("app_req.en", 1'b1, app_req.en);
            next_cycle();
        end
        hold_rdy = 1'b0;
        wait_not_busy(1'b1, 1'b0);
        check_bit("app_status.rdy", 1'b1, app_status.rdy);
        wait_read_data(got);
        check_word("rd_data", d, got);
        drain_queues();
    endtask

    task automatic random_traffic();
        logic [ADDR_WIDTH-1:0] a;
        logic is_read;
        rand_stall = 1'b1;
        repeat (40) begin
            a       = ADDR_WIDTH'($urandom_range(15, 0));   // Small range, lots of reuse
            is_read = 1'($urandom_range(1, 0));
            send_request(is_read, !is_read, a, {$urandom, $urandom, $urandom, $urandom});
        end
        drain_queues();
        rand_stall = 1'b0;
    endtask

    initial begin
        errors = 0;
        void'($urandom(9));
        ui_clk          = 1'b0;
        ui_clk_sync_rst = 1'b1;
        wr_en           = 1'b0;
        rd_en           = 1'b0;
        wr_addr         = '0;
        rd_addr         = '0;
        wr_data         = '0;
        rand_stall      = 1'b0;
        hold_rdy        = 1'b0;
        hold_wdf_rdy    = 1'b0;
        for (int i = 0; i < 256; i++) begin
            exp_mem[i] = initial_word(8'(i));
        end
        repeat (8) @(posedge ui_clk);
        #1;
        ui_clk_sync_rst = 1'b0;

        calibration_wait();
        write_then_read();
        same_cycle_conflict();
        back_pressure();
        random_traffic();

        errors += DUT.u_props.assert_fails;
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* filelist.f */
src/ddr_ui_pkg.sv
src/ddr_cmd_sequencer.sv
src/ddr_app_driver.sv
src/ddr_ui_ctrl.sv
dv/app_mem_model.sv
dv/ddr_ui_ctrl_properties.sv
dv/tb_ddr_ui_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f filelist.f --top-module tb_ddr_ui_ctrl -o tb_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/tb_sim +verilator+error+limit+1000 > sim.log 2>&1 ; cat sim.log

grep -q "^Finished with no errors$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
